//--- filelist.f
hw/core_pkg.sv
hw/decode_if.sv
hw/ifu.sv
hw/regfile.sv
hw/idu.sv
hw/exu.sv
hw/core_top.sv
tests/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_core.sv
// core testbench
`timescale 1ns/100ps

module tb_core;
	import core_pkg::*;

	typedef struct packed {
		logic [31:0] next_pc;
		logic        st_valid;
		logic [31:0] st_addr;
		logic [31:0] st_data;
		logic        halt;
	} step_t;

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic        exec;
	logic        mem_we;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        halted;

	logic [31:0] prog [0:255];
	logic [31:0] ref_pc;
	logic [31:0] ref_regs [0:31];
	logic        ref_halted;
	logic        checking;
	logic        halt_pending;
	step_t       exp_res;
	int          steps_done;
	int          cycle_count;
	int          cycle_limit;
	string       test_name;

	core_top u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.exec       (exec),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.halted     (halted)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// instruction memory answers one cycle after the address
	always @(posedge clk)
		imem_rdata <= prog[imem_addr[9:2]];

	// instruction encoders
	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	// architectural model stepping ref_pc and ref_regs over one instruction
	function automatic step_t ref_step(input logic [31:0] inst);
		step_t       r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] val;
		logic        wr;
		a = ref_regs[inst[19:15]];
		b = ref_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		r = '0;
		r.next_pc = ref_pc + 32'd4;
		val = '0;
		wr = 1'b0;
		case (inst[6:0])
			op_imm: if (inst[14:12] == 3'b000) begin
				val = a + imm_i;
				wr = 1'b1;
			end
			op_lui: begin
				val = {inst[31:12], 12'b0};
				wr = 1'b1;
			end
			op_auipc: begin
				val = ref_pc + {inst[31:12], 12'b0};
				wr = 1'b1;
			end
			op_jal: begin
				val = ref_pc + 32'd4;
				wr = 1'b1;
				r.next_pc = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			op_jalr: if (inst[14:12] == 3'b000) begin
				val = ref_pc + 32'd4;
				wr = 1'b1;
				r.next_pc = (a + imm_i) & ~32'd1;
			end
			op_store: if (inst[14:12] == 3'b010) begin
				r.st_valid = 1'b1;
				r.st_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				r.st_data = b;
			end
			op_system: if (inst == ebreak_word) begin
				r.halt = 1'b1;
				r.next_pc = ref_pc;
			end
			default: ;
		endcase
		if (wr && inst[11:7] != 5'd0)
			ref_regs[inst[11:7]] = val;
		return r;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
		$display("Test failed");
		$fatal(1, "mismatch in %s", test_name);
	endtask

	// compare each execute cycle against the model and halted one cycle later
	always @(negedge clk) begin
		if (rst_n && checking) begin
			if (halt_pending) begin
				assert (halted == exp_res.halt)
				else report_mismatch("halted", 32'(exp_res.halt), 32'(halted));
				halt_pending = 1'b0;
			end
			if (exec) begin
				assert (imem_addr == ref_pc)
				else report_mismatch("fetch address", ref_pc, imem_addr);
				exp_res = ref_step(prog[ref_pc[9:2]]);
				assert (mem_we == exp_res.st_valid)
				else report_mismatch("mem_we", 32'(exp_res.st_valid), 32'(mem_we));
				if (exp_res.st_valid) begin
					assert (mem_addr == exp_res.st_addr)
					else report_mismatch("mem_addr", exp_res.st_addr, mem_addr);
					assert (mem_wdata == exp_res.st_data)
					else report_mismatch("mem_wdata", exp_res.st_data, mem_wdata);
				end
				ref_pc = exp_res.next_pc;
				ref_halted = exp_res.halt;
				steps_done++;
				halt_pending = 1'b1;
			end else begin
				// store strobe belongs to the execute cycle only
				assert (!mem_we)
				else report_mismatch("mem_we in fetch", 32'd0, 32'(mem_we));
			end
		end
	end

	always @(negedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: %s did not finish within %0d cycles", test_name, cycle_limit);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	// unused words decode as a custom opcode, which the core skips
	task automatic clear_prog();
		logic [31:0] addr;
		for (int i = 0; i < 256; i++) begin
			addr = 32'(i) * 32'd4;
			prog[i] = {addr[24:0], 7'b000_1011};
		end
	endtask

	task automatic run_program(input string name, input int n_steps);
		test_name = name;
		cycle_limit = 2 * n_steps + 50;
		cycle_count = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		checking = 1'b0;
		repeat (2) @(posedge clk);
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		ref_pc = reset_pc;
		ref_halted = 1'b0;
		steps_done = 0;
		halt_pending = 1'b0;
		checking = 1'b1;
		rst_n <= 1'b1;
		@(negedge clk);
		assert (imem_addr == reset_pc) else report_mismatch("reset pc", reset_pc, imem_addr);
		assert (!mem_we && !halted && !exec)
		else report_mismatch("reset strobes", 32'd0, {29'd0, exec, mem_we, halted});
		while (!((steps_done >= n_steps || ref_halted) && !halt_pending))
			@(posedge clk);
		checking = 1'b0;
	endtask

	task automatic check_frozen(input int n_cycles);
		logic [31:0] held;
		@(negedge clk);
		held = ref_pc;
		repeat (n_cycles) begin
			@(negedge clk);
			assert (imem_addr == held) else report_mismatch("frozen pc", held, imem_addr);
			assert (!mem_we && !exec && halted)
			else report_mismatch("halt state", 32'd1, {29'd0, exec, mem_we, halted});
		end
	endtask

	function automatic logic [31:0] random_inst(input int idx);
		logic [4:0] rd;
		logic [4:0] rs1;
		int         tgt;
		rd = 5'($urandom_range(0, 7));
		rs1 = 5'($urandom_range(0, 7));
		tgt = int'($urandom_range(0, 199));
		case ($urandom_range(0, 5))
			0: return enc_i(op_imm, 3'b000, rd, rs1, 12'($urandom));
			1: return enc_u(op_lui, rd, 20'($urandom));
			2: return enc_u(op_auipc, rd, 20'($urandom));
			3: return enc_s(rd, rs1, 12'($urandom));
			// jumps land on an instruction of the program
			4: return enc_j(rd, (tgt - idx) * 4);
			default: return enc_i(op_jalr, 3'b000, rd, 5'd0,
				12'(tgt * 4 + int'($urandom_range(0, 1))));
		endcase
	endfunction

	initial begin
		rst_n = 1'b0;
		imem_rdata = '0;
		checking = 1'b0;
		halt_pending = 1'b0;
		cycle_count = 0;
		cycle_limit = 100;
		test_name = "init";
		void'($urandom(52091));

		clear_prog();
		prog[0] = enc_i(op_imm, 3'b000, 5'd1, 5'd0, 12'hffb);
		prog[1] = enc_u(op_lui, 5'd2, 20'habcde);
		prog[2] = enc_i(op_imm, 3'b000, 5'd2, 5'd2, 12'h7ff);
		prog[3] = enc_u(op_auipc, 5'd3, 20'h12345);
		prog[4] = enc_s(5'd1, 5'd0, 12'h000);
		prog[5] = enc_s(5'd2, 5'd3, 12'hffc);
		prog[6] = enc_s(5'd3, 5'd1, 12'h008);
		prog[7] = ebreak_word;
		run_program("alu_store", 8);

		clear_prog();
		prog[0] = enc_j(5'd1, 12);
		prog[1] = enc_s(5'd0, 5'd0, 12'h100);
		prog[2] = enc_s(5'd0, 5'd0, 12'h104);
		prog[3] = enc_s(5'd1, 5'd0, 12'h000);
		prog[4] = enc_i(op_imm, 3'b000, 5'd6, 5'd0, 12'd33);
		prog[5] = enc_i(op_jalr, 3'b000, 5'd7, 5'd6, 12'd0);
		prog[6] = enc_s(5'd0, 5'd0, 12'h108);
		prog[7] = enc_s(5'd0, 5'd0, 12'h10c);
		prog[8] = enc_s(5'd7, 5'd0, 12'h004);
		prog[9] = ebreak_word;
		run_program("jumps", 6);

		clear_prog();
		prog[0] = enc_i(op_imm, 3'b000, 5'd0, 5'd0, 12'd99);
		prog[1] = enc_s(5'd0, 5'd0, 12'h000);
		prog[2] = enc_i(op_imm, 3'b000, 5'd4, 5'd0, 12'd7);
		prog[3] = 32'h0000_000b;
		// slti is outside the subset and must leave x4 at 7
		prog[4] = enc_i(op_imm, 3'b010, 5'd4, 5'd0, 12'd5);
		prog[5] = enc_s(5'd4, 5'd0, 12'h00c);
		prog[6] = ebreak_word;
		run_program("x0_unknown", 7);

		clear_prog();
		for (int i = 0; i < 200; i++)
			prog[i] = random_inst(i);
		run_program("random", 200);

		clear_prog();
		prog[0] = enc_i(op_imm, 3'b000, 5'd1, 5'd0, 12'd3);
		prog[1] = enc_s(5'd1, 5'd0, 12'h000);
		prog[2] = ebreak_word;
		prog[3] = enc_i(op_imm, 3'b000, 5'd1, 5'd0, 12'd5);
		prog[4] = enc_s(5'd1, 5'd0, 12'h004);
		run_program("ebreak", 3);
		check_frozen(20);

		$display("Test passed");
		$finish;
	end

endmodule

//--- hw/core_top.sv
// rv32i subset core
`timescale 1ns/100ps

module core_top (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic [core_pkg::xlen-1:0] imem_addr,
	input  logic [core_pkg::xlen-1:0] imem_rdata,
	output logic                     exec,
	output logic                     mem_we,
	output logic [core_pkg::xlen-1:0] mem_addr,
	output logic [core_pkg::xlen-1:0] mem_wdata,
	output logic                     halted
);
	import core_pkg::*;

	logic [xlen-1:0]       next_pc;
	logic                  is_ebreak;
	logic                  wen;
	logic [reg_addr_w-1:0] waddr;
	logic [xlen-1:0]       wdata;

	decode_if u_dec_if (.clk(clk));

	// the pc doubles as the fetch address
	ifu u_ifu (
		.clk      (clk),
		.rst_n    (rst_n),
		.next_pc  (next_pc),
		.halt_req (is_ebreak),
		.pc       (imem_addr),
		.exec     (exec),
		.halted   (halted)
	);

	idu u_idu (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (imem_rdata),
		.pc_in     (imem_addr),
		.exec      (exec),
		.wen       (wen),
		.waddr     (waddr),
		.wdata     (wdata),
		.dec       (u_dec_if.decoder),
		.is_ebreak (is_ebreak)
	);

	exu u_exu (
		.dec       (u_dec_if.executor),
		.next_pc   (next_pc),
		.wen       (wen),
		.waddr     (waddr),
		.wdata     (wdata),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

endmodule

//--- hw/exu.sv
// execute unit
`timescale 1ns/100ps

module exu (
	decode_if.executor                     dec,
	output logic [core_pkg::xlen-1:0]       next_pc,
	output logic                           wen,
	output logic [core_pkg::reg_addr_w-1:0] waddr,
	output logic [core_pkg::xlen-1:0]       wdata,
	output logic                           mem_we,
	output logic [core_pkg::xlen-1:0]       mem_addr,
	output logic [core_pkg::xlen-1:0]       mem_wdata
);
	import core_pkg::*;

	logic [xlen-1:0] sum;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] jump_target;

	// single adder serves every kept instruction
	assign sum      = dec.src1 + dec.src2;
	assign pc_plus4 = dec.pc + xlen'(4);

	// jalr drops bit 0 of its target
	assign jump_target = dec.is_jalr ? {sum[xlen-1:1], 1'b0} : sum;
	assign next_pc     = dec.is_jump ? jump_target : pc_plus4;

	// writes to x0 never leave the executor
	assign wen   = (dec.wb_sel != wb_none) && (dec.rd != '0);
	assign waddr = dec.rd;
	assign wdata = (dec.wb_sel == wb_link) ? pc_plus4 : sum;

	// sw address comes from rs1 plus the S immediate
	assign mem_we    = dec.is_store;
	assign mem_addr  = sum;
	assign mem_wdata = dec.store_data;

	// the decoder must never flag a store that also writes a register
	a_store_no_wb: assert property (
		@(posedge dec.clk)
		!(dec.is_store && dec.wb_sel != wb_none)
	);

endmodule

//--- hw/idu.sv
// instruction decoder
`timescale 1ns/100ps

module idu (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [core_pkg::xlen-1:0]       inst,
	input  logic [core_pkg::xlen-1:0]       pc_in,
	input  logic                           exec,
	input  logic                           wen,
	input  logic [core_pkg::reg_addr_w-1:0] waddr,
	input  logic [core_pkg::xlen-1:0]       wdata,
	decode_if.decoder                      dec,
	output logic                           is_ebreak
);
	import core_pkg::*;

	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm;
	logic [xlen-1:0]       rs1_val;
	logic [xlen-1:0]       rs2_val;
	logic                  inst_addi;
	logic                  inst_lui;
	logic                  inst_auipc;
	logic                  inst_jal;
	logic                  inst_jalr;
	logic                  inst_sw;
	logic                  src1_from_pc;
	logic                  src2_from_imm;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	// every flag is qualified by exec so the fetch cycle decodes as nothing
	assign inst_addi  = exec && opcode == op_imm && funct3 == f3_addi;
	assign inst_lui   = exec && opcode == op_lui;
	assign inst_auipc = exec && opcode == op_auipc;
	assign inst_jal   = exec && opcode == op_jal;
	assign inst_jalr  = exec && opcode == op_jalr && funct3 == f3_jalr;
	assign inst_sw    = exec && opcode == op_store && funct3 == f3_sw;
	assign is_ebreak  = exec && opcode == op_system && inst[31:7] == ebreak_word[31:7];

	// immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

	assign imm = ({xlen{inst_addi | inst_jalr}}  & imm_i) |
	             ({xlen{inst_lui | inst_auipc}}  & imm_u) |
	             ({xlen{inst_jal}}               & imm_j) |
	             ({xlen{inst_sw}}                & imm_s);

	regfile u_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.waddr  (waddr),
		.wdata  (wdata),
		.wen    (wen),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val)
	);

	// operand selection, lui adds its immediate to zero
	assign src1_from_pc  = inst_jal || inst_auipc;
	assign src2_from_imm = inst_addi || inst_lui || inst_auipc ||
	                       inst_jal || inst_jalr || inst_sw;

	assign dec.src1 = src1_from_pc ? pc_in :
	                  inst_lui     ? '0    : rs1_val;
	assign dec.src2 = src2_from_imm ? imm : rs2_val;

	assign dec.pc         = pc_in;
	assign dec.rd         = inst[11:7];
	assign dec.is_jump    = inst_jal || inst_jalr;
	assign dec.is_jalr    = inst_jalr;
	assign dec.is_store   = inst_sw;
	assign dec.store_data = rs2_val;

	always_comb begin
		if (inst_addi || inst_lui || inst_auipc)
			dec.wb_sel = wb_sum;
		else if (inst_jal || inst_jalr)
			dec.wb_sel = wb_link;
		else
			dec.wb_sel = wb_none;
	end

endmodule

//--- hw/regfile.sv
// integer register file
`timescale 1ns/100ps

module regfile (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [core_pkg::reg_addr_w-1:0] raddr1,
	input  logic [core_pkg::reg_addr_w-1:0] raddr2,
	input  logic [core_pkg::reg_addr_w-1:0] waddr,
	input  logic [core_pkg::xlen-1:0]       wdata,
	input  logic                           wen,
	output logic [core_pkg::xlen-1:0]       rdata1,
	output logic [core_pkg::xlen-1:0]       rdata2
);
	import core_pkg::*;

	// x1..x31, x0 has no storage
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous read ports
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	// a write aimed at x0 must leave it reading zero on both ports
	a_x0_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wen && waddr == '0) |=>
			((raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0))
	);

endmodule

//--- hw/ifu.sv
// fetch unit
`timescale 1ns/100ps

module ifu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [core_pkg::xlen-1:0] next_pc,
	input  logic                     halt_req,
	output logic [core_pkg::xlen-1:0] pc,
	output logic                     exec,
	output logic                     halted
);
	import core_pkg::*;

	// low in fetch, high in execute
	logic exec_phase;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= reset_pc;
			exec_phase <= 1'b0;
			halted     <= 1'b0;
		end else if (!halted) begin
			if (!exec_phase) begin
				exec_phase <= 1'b1;
			end else begin
				exec_phase <= 1'b0;
				// ebreak freezes the pc where it is
				if (halt_req)
					halted <= 1'b1;
				else
					pc <= next_pc;
			end
		end
	end

	// phase never reaches execute once halted
	assign exec = exec_phase;

	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00
	);

endmodule

//--- hw/decode_if.sv
// decoder to executor link
`timescale 1ns/100ps

interface decode_if (
	input logic clk
);
	import core_pkg::*;

	logic [xlen-1:0]       pc;
	logic [xlen-1:0]       src1;
	logic [xlen-1:0]       src2;
	logic [reg_addr_w-1:0] rd;
	wb_sel_t               wb_sel;
	logic                  is_jump;
	logic                  is_jalr;
	logic                  is_store;
	// raw rs2 value, only meaningful for sw
	logic [xlen-1:0]       store_data;

	modport decoder (
		output pc, src1, src2, rd, wb_sel, is_jump, is_jalr, is_store, store_data
	);

	// clk is only used by checks on the executor side
	modport executor (
		input clk, pc, src1, src2, rd, wb_sel, is_jump, is_jalr, is_store, store_data
	);

endinterface

//--- hw/core_pkg.sv
// core shared definitions
package core_pkg;

	// data path and register index widths
	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] reset_pc = '0;

	// major opcodes of the kept instructions
	localparam logic [6:0] op_imm    = 7'b001_0011;
	localparam logic [6:0] op_lui    = 7'b011_0111;
	localparam logic [6:0] op_auipc  = 7'b001_0111;
	localparam logic [6:0] op_jal    = 7'b110_1111;
	localparam logic [6:0] op_jalr   = 7'b110_0111;
	localparam logic [6:0] op_store  = 7'b010_0011;
	localparam logic [6:0] op_system = 7'b111_0011;

	// funct3 values that qualify addi, jalr and sw
	localparam logic [2:0] f3_addi = 3'b000;
	localparam logic [2:0] f3_jalr = 3'b000;
	localparam logic [2:0] f3_sw   = 3'b010;

	// ebreak has only one legal encoding
	localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

	// what an instruction writes back to rd
	typedef enum logic [1:0] {
		wb_none = 2'd0,
		wb_sum  = 2'd1,
		wb_link = 2'd2
	} wb_sel_t;

endpackage
